//--- dcache_wb.f
+incdir+tests
logic/dcache_types_pkg.sv
logic/dcache_fsm_pkg.sv
logic/array_if.sv
logic/cache_array.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
tests/tb_dcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f dcache_wb.f \
    --top-module tb_dcache \
    -Mdir obj_dir

./obj_dir/Vtb_dcache | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

//--- tests/dcache_tests.svh
task automatic apply_reset();
    @(posedge CLK);
    nRST <= 1'b0;
    dmem_ren <= 1'b0;
    dmem_wen <= 1'b0;
    halt <= 1'b0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    rd_log.delete();
    wr_log.delete();
endtask

// hold the request until dhit, waited counts the cycles after the first
task automatic access(input logic write, input dcache_types_pkg::addr_t addr,
                      input dcache_types_pkg::word_t wdata,
                      output dcache_types_pkg::word_t rdata, output int waited);
    @(posedge CLK);
    dmem_ren <= !write;
    dmem_wen <= write;
    dmem_addr <= addr;
    dmem_store <= wdata;
    waited = 0;
    @(negedge CLK);
    while (!dhit) begin
        @(negedge CLK);
        waited++;
    end
    rdata = dmem_load;
    @(posedge CLK);  // a store lands here
    dmem_ren <= 1'b0;
    dmem_wen <= 1'b0;
endtask

task automatic read_word(input dcache_types_pkg::addr_t addr,
                         output dcache_types_pkg::word_t rdata, output int waited);
    access(1'b0, addr, '0, rdata, waited);
endtask

task automatic store_word(input dcache_types_pkg::addr_t addr,
                          input dcache_types_pkg::word_t wdata);
    dcache_types_pkg::word_t unused_rd;
    int unused_wait;
    access(1'b1, addr, wdata, unused_rd, unused_wait);
endtask

task automatic reset_idle();
    int errs;
    errs = err_count;
    apply_reset();
    repeat (4) begin
        @(negedge CLK);
        check_bit("dhit idle", dhit, 1'b0);
        check_bit("flushed idle", flushed, 1'b0);
        check_bit("mem_ren idle", mem_ren, 1'b0);
        check_bit("mem_wen idle", mem_wen, 1'b0);
    end
    end_test("reset idle", errs);
endtask

task automatic read_miss_then_hit(input string name);
    int errs;
    int waited;
    dcache_types_pkg::addr_t a;
    dcache_types_pkg::word_t rd;
    errs = err_count;
    apply_reset();
    a = blk_addr(5, 1, 1);
    read_word(a, rd, waited);
    check_word("read miss data", rd, fresh_word(a));
    check_bit("two fill reads", rd_log.size() == 2, 1'b1);
    if (rd_log.size() == 2) begin
        check_word("first fill address", rd_log[0], blk_addr(5, 1, 0));
    end
    rd_log.delete();
    read_word(a, rd, waited);
    check_word("read hit data", rd, fresh_word(a));
    check_bit("hit in first cycle", waited == 0, 1'b1);
    read_word(blk_addr(5, 1, 0), rd, waited);
    check_word("other block word", rd, fresh_word(blk_addr(5, 1, 0)));
    check_bit("no mem_ren on hits", rd_log.size() == 0, 1'b1);
    end_test(name, errs);
endtask

task automatic store_hit_writeback(input string name);
    int errs;
    int waited;
    dcache_types_pkg::addr_t a;
    dcache_types_pkg::word_t rd;
    errs = err_count;
    apply_reset();
    a = blk_addr(1, 2, 0);
    store_word(a, 32'hCAFE_0001);
    read_word(a, rd, waited);
    check_word("load after store", rd, 32'hCAFE_0001);
    check_bit("load after store hits", waited == 0, 1'b1);
    check_bit("nothing written yet", wr_log.size() == 0, 1'b1);
    read_word(blk_addr(2, 2, 0), rd, waited);
    read_word(blk_addr(3, 2, 0), rd, waited);  // evicts a
    check_word("third tag data", rd, fresh_word(blk_addr(3, 2, 0)));
    check_bit("one block written back", wr_log.size() == 2, 1'b1);
    check_word("stored word in memory", mem_peek(a), 32'hCAFE_0001);
    check_word("other word unchanged", mem_peek(a + 4), fresh_word(a + 4));
    end_test(name, errs);
endtask

task automatic recent_way_replacement();
    int errs;
    int waited;
    dcache_types_pkg::word_t rd;
    errs = err_count;
    apply_reset();
    read_word(blk_addr(1, 3, 0), rd, waited);
    read_word(blk_addr(2, 3, 0), rd, waited);
    read_word(blk_addr(1, 3, 0), rd, waited);
    check_bit("a still cached", waited == 0, 1'b1);
    read_word(blk_addr(3, 3, 0), rd, waited);  // replaces b
    check_bit("clean victim not written", wr_log.size() == 0, 1'b1);
    rd_log.delete();
    read_word(blk_addr(1, 3, 0), rd, waited);
    check_bit("a hits after c", waited == 0, 1'b1);
    check_bit("no mem_ren for a", rd_log.size() == 0, 1'b1);
    read_word(blk_addr(2, 3, 0), rd, waited);
    check_word("b data", rd, fresh_word(blk_addr(2, 3, 0)));
    check_bit("b refetched", rd_log.size() == 2, 1'b1);
    if (rd_log.size() != 0) begin
        check_word("b block address", rd_log[0], blk_addr(2, 3, 0));
    end
    end_test("recent-way replacement", errs);
endtask

task automatic flush_on_halt();
    int errs;
    int waited;
    dcache_types_pkg::word_t rd;
    dcache_types_pkg::addr_t st_addr [4];
    dcache_types_pkg::word_t st_val [4];
    errs = err_count;
    apply_reset();
    st_addr[0] = blk_addr(1, 0, 0);
    st_addr[1] = blk_addr(2, 0, 1);  // same set, other way
    st_addr[2] = blk_addr(1, 4, 1);
    st_addr[3] = blk_addr(3, 6, 0);
    for (int i = 0; i < 4; i++) begin
        st_val[i] = 32'hD00D_0000 + dcache_types_pkg::word_t'(i);
        store_word(st_addr[i], st_val[i]);
    end
    read_word(blk_addr(5, 7, 0), rd, waited);
    wr_log.delete();
    @(posedge CLK);
    halt <= 1'b1;
    @(negedge CLK);
    while (!flushed) begin
        @(negedge CLK);
    end
    check_bit("two writes per dirty block", wr_log.size() == 8, 1'b1);
    for (int i = 0; i < 4; i++) begin
        check_word("flushed word", mem_peek(st_addr[i]), st_val[i]);
        check_word("flushed neighbour", mem_peek(st_addr[i] ^ 4), fresh_word(st_addr[i] ^ 4));
    end
    check_bit("clean line not written", mem_written[blk_addr(5, 7, 0) >> 2], 1'b0);
    repeat (3) begin
        @(negedge CLK);
        check_bit("flushed held", flushed, 1'b1);
        check_bit("quiet after flush", mem_ren || mem_wen, 1'b0);
    end
    end_test("flush on halt", errs);
endtask

//--- tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int NUM_TESTS = 7;
    localparam int MEM_WORDS = 1024;  // test addresses stay below 4 KB
    localparam int OFF_LSB   = dcache_types_pkg::BYTE_OFF_BITS;
    localparam int IDX_LSB   = OFF_LSB + 1;
    localparam int TAG_LSB   = IDX_LSB + dcache_types_pkg::DEFAULT_IDX_BITS;
    localparam dcache_types_pkg::word_t PATTERN = 32'h5A3C_96E1;

    logic                    CLK = 1'b0;
    logic                    nRST;
    logic                    dmem_ren;
    logic                    dmem_wen;
    logic                    halt;
    dcache_types_pkg::addr_t dmem_addr;
    dcache_types_pkg::word_t dmem_store;
    logic                    dhit;
    logic                    flushed;
    dcache_types_pkg::word_t dmem_load;
    logic                    mem_ren;
    logic                    mem_wen;
    dcache_types_pkg::addr_t mem_addr;
    dcache_types_pkg::word_t mem_store;
    dcache_types_pkg::word_t mem_load;
    logic                    mem_wait = 1'b0;

    // memory model state
    dcache_types_pkg::word_t mem_data [MEM_WORDS];
    logic [MEM_WORDS-1:0]    mem_written;
    logic [1:0]              stall_cnt;
    logic [15:0]             lfsr;
    logic                    stall_en;
    dcache_types_pkg::addr_t rd_log [$];
    dcache_types_pkg::addr_t wr_log [$];

    int err_count;
    int test_count;

    dcache_top #(.IDX_BITS(dcache_types_pkg::DEFAULT_IDX_BITS)) u_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halt       (halt),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .flushed    (flushed),
        .dmem_load  (dmem_load),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait)
    );

    always #5 CLK = ~CLK;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic dcache_types_pkg::word_t fresh_word(input dcache_types_pkg::addr_t a);
        return a ^ PATTERN;
    endfunction

    function automatic dcache_types_pkg::word_t mem_peek(input dcache_types_pkg::addr_t a);
        return mem_written[a[11:2]] ? mem_data[a[11:2]] : fresh_word(a);
    endfunction

    function automatic dcache_types_pkg::addr_t blk_addr(input int tag, input int idx,
                                                         input int off);
        return dcache_types_pkg::addr_t'((tag << TAG_LSB) | (idx << IDX_LSB) | (off << OFF_LSB));
    endfunction

    assign mem_load = mem_peek(mem_addr);

    // one word completes in a cycle with mem_wait low
    always @(posedge CLK) begin : mem_model
        logic [1:0] stall;
        stall = 2'd0;
        if (!nRST) begin
            mem_written <= '0;
            lfsr = 16'd98;
            stall_cnt <= 2'd0;
            mem_wait <= 1'b0;
        end else if ((mem_ren || mem_wen) && !mem_wait) begin
            if (mem_wen) begin
                mem_data[mem_addr[11:2]] <= mem_store;
                mem_written[mem_addr[11:2]] <= 1'b1;
                wr_log.push_back(mem_addr);
            end else begin
                rd_log.push_back(mem_addr);
            end
            if (stall_en) begin
                for (int i = 0; i < 2; i++) begin
                    lfsr = lfsr_step(lfsr);
                    stall = {stall[0], lfsr[0]};
                end
            end
            stall_cnt <= stall;  // stretch for the next word
            mem_wait <= (stall != 2'd0);
        end else if ((mem_ren || mem_wen) && mem_wait) begin
            stall_cnt <= stall_cnt - 2'd1;
            mem_wait <= (stall_cnt != 2'd1);
        end
    end

    task automatic check_word(input string what, input dcache_types_pkg::word_t got,
                              input dcache_types_pkg::word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error: %0t ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("** Error: %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    `include "dcache_tests.svh"

    initial begin
        nRST <= 1'b0;
        dmem_ren <= 1'b0;
        dmem_wen <= 1'b0;
        halt <= 1'b0;
        dmem_addr <= '0;
        dmem_store <= '0;
        stall_en = 1'b0;
        err_count = 0;
        test_count = 0;

        reset_idle();
        read_miss_then_hit("read miss then hit");
        store_hit_writeback("store hit and write-back");
        recent_way_replacement();
        stall_en = 1'b1;
        read_miss_then_hit("read miss then hit, stalled");
        store_hit_writeback("store hit and write-back, stalled");
        stall_en = 1'b0;
        flush_on_halt();  // last, FLUSHED holds until reset

        $display("tests run: %0d, checks failed: %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * 2000);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int IDX_BITS = dcache_types_pkg::DEFAULT_IDX_BITS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     dmem_ren,
    input  logic                     dmem_wen,
    input  logic                     halt,
    input  dcache_types_pkg::addr_t  dmem_addr,
    input  dcache_types_pkg::word_t  dmem_store,
    output logic                     dhit,
    output logic                     flushed,
    output dcache_types_pkg::word_t  dmem_load,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output dcache_types_pkg::addr_t  mem_addr,
    output dcache_types_pkg::word_t  mem_store,
    input  dcache_types_pkg::word_t  mem_load,
    input  logic                     mem_wait
);

    array_if #(.IDX_BITS(IDX_BITS)) arr_bus ();

    cache_array #(.IDX_BITS(IDX_BITS)) u_array (
        .CLK  (CLK),
        .nRST (nRST),
        .arr  (arr_bus.array)
    );

    cache_ctrl #(.IDX_BITS(IDX_BITS)) u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .arr        (arr_bus.ctrl),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .halt       (halt),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dhit       (dhit),
        .dmem_load  (dmem_load),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait)
    );

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int IDX_BITS = dcache_types_pkg::DEFAULT_IDX_BITS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    array_if.ctrl                    arr,
    input  logic                     dmem_ren,
    input  logic                     dmem_wen,
    input  logic                     halt,
    input  dcache_types_pkg::addr_t  dmem_addr,
    input  dcache_types_pkg::word_t  dmem_store,
    output logic                     dhit,
    output dcache_types_pkg::word_t  dmem_load,
    output logic                     flushed,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output dcache_types_pkg::addr_t  mem_addr,
    output dcache_types_pkg::word_t  mem_store,
    input  dcache_types_pkg::word_t  mem_load,
    input  logic                     mem_wait
);
    localparam int OFF_BIT  = dcache_types_pkg::BYTE_OFF_BITS;
    localparam int TAG_LSB  = IDX_BITS + 1 + OFF_BIT;
    localparam int TAG_BITS = 32 - TAG_LSB;

    dcache_fsm_pkg::ctrl_state_t state, next_state;

    // flush slot, way in the top bit
    logic [IDX_BITS:0]   slot, next_slot;
    logic                slot_way;
    logic [IDX_BITS-1:0] slot_idx;
    logic                slot_last;

    logic [TAG_BITS-1:0] req_tag;
    logic [IDX_BITS-1:0] req_idx;
    logic                req_off;

    assign req_tag   = dmem_addr[31 -: TAG_BITS];
    assign req_idx   = dmem_addr[TAG_LSB-1 -: IDX_BITS];
    assign req_off   = dmem_addr[OFF_BIT];
    assign slot_way  = slot[IDX_BITS];
    assign slot_idx  = slot[IDX_BITS-1:0];
    assign slot_last = &slot;

    assign dmem_load = arr.sel_word;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dcache_fsm_pkg::ACCESS;
            slot  <= '0;
        end else begin
            state <= next_state;
            slot  <= next_slot;
        end
    end

    always_comb begin
        next_state    = state;
        next_slot     = slot;
        arr.look_addr = dmem_addr;
        arr.sel_way   = arr.victim_way;
        arr.sel_off   = 1'b0;
        arr.touch     = 1'b0;
        arr.wr_kind   = dcache_fsm_pkg::WR_NONE;
        arr.wr_data   = mem_load;
        dhit          = 1'b0;
        flushed       = 1'b0;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_addr      = '0;
        mem_store     = arr.sel_word;

        case (state)
            dcache_fsm_pkg::ACCESS: begin
                arr.sel_off = req_off;
                if (dmem_ren || dmem_wen) begin
                    if (arr.hit) begin
                        arr.sel_way = arr.hit_way;
                        arr.touch   = 1'b1;
                        dhit        = 1'b1;
                        if (dmem_wen) begin
                            arr.wr_kind = dcache_fsm_pkg::WR_STORE;
                            arr.wr_data = dmem_store;
                        end
                    end else if (arr.victim_valid && arr.victim_dirty) begin
                        next_state = dcache_fsm_pkg::WB0;
                    end else begin
                        next_state = dcache_fsm_pkg::FILL0;
                    end
                end else if (halt) begin
                    next_state = dcache_fsm_pkg::FLUSH_SCAN;
                end
            end
            dcache_fsm_pkg::WB0, dcache_fsm_pkg::WB1: begin
                arr.sel_off = (state == dcache_fsm_pkg::WB1);
                mem_wen     = 1'b1;
                mem_addr    = {arr.victim_tag, req_idx, arr.sel_off, {OFF_BIT{1'b0}}};
                if (!mem_wait) begin
                    next_state = (state == dcache_fsm_pkg::WB0) ? dcache_fsm_pkg::WB1
                                                                : dcache_fsm_pkg::FILL0;
                end
            end
            dcache_fsm_pkg::FILL0, dcache_fsm_pkg::FILL1: begin
                arr.sel_off = (state == dcache_fsm_pkg::FILL1);
                mem_ren     = 1'b1;
                mem_addr    = {req_tag, req_idx, arr.sel_off, {OFF_BIT{1'b0}}};
                if (!mem_wait) begin
                    if (state == dcache_fsm_pkg::FILL0) begin
                        arr.wr_kind = dcache_fsm_pkg::WR_FILL_WORD;
                        next_state  = dcache_fsm_pkg::FILL1;
                    end else begin
                        arr.wr_kind = dcache_fsm_pkg::WR_FILL_LAST;
                        next_state  = dcache_fsm_pkg::ACCESS;  // request hits next cycle
                    end
                end
            end
            dcache_fsm_pkg::FLUSH_SCAN: begin
                arr.look_addr = {{TAG_BITS{1'b0}}, slot_idx, 1'b0, {OFF_BIT{1'b0}}};
                arr.sel_way   = slot_way;
                if (arr.sel_dirty) begin
                    next_state = dcache_fsm_pkg::FLUSH0;
                end else if (slot_last) begin
                    next_state = dcache_fsm_pkg::FLUSHED;
                end else begin
                    next_slot = slot + 1'b1;
                end
            end
            dcache_fsm_pkg::FLUSH0, dcache_fsm_pkg::FLUSH1: begin
                arr.sel_off   = (state == dcache_fsm_pkg::FLUSH1);
                arr.look_addr = {{TAG_BITS{1'b0}}, slot_idx, arr.sel_off, {OFF_BIT{1'b0}}};
                arr.sel_way   = slot_way;
                mem_wen       = 1'b1;
                mem_addr      = {arr.sel_tag, slot_idx, arr.sel_off, {OFF_BIT{1'b0}}};
                if (!mem_wait) begin
                    if (state == dcache_fsm_pkg::FLUSH0) begin
                        next_state = dcache_fsm_pkg::FLUSH1;
                    end else if (slot_last) begin
                        next_state = dcache_fsm_pkg::FLUSHED;
                    end else begin
                        next_slot  = slot + 1'b1;
                        next_state = dcache_fsm_pkg::FLUSH_SCAN;
                    end
                end
            end
            dcache_fsm_pkg::FLUSHED: begin
                flushed = 1'b1;  // until reset
            end
            default: begin
                next_state = dcache_fsm_pkg::ACCESS;
            end
        endcase
    end

    a_one_mem_req: assert property (
        @(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen)
    );

    // once flushed, stay flushed and quiet
    a_flushed_quiet: assert property (
        @(posedge CLK) disable iff (!nRST) flushed |=> flushed && !mem_ren && !mem_wen
    );

endmodule

//--- logic/cache_array.sv
`timescale 1ns/1ps

module cache_array #(
    parameter int IDX_BITS = dcache_types_pkg::DEFAULT_IDX_BITS
) (
    input logic     CLK,
    input logic     nRST,
    array_if.array  arr
);
    localparam int SETS     = 1 << IDX_BITS;
    localparam int OFF_BIT  = dcache_types_pkg::BYTE_OFF_BITS;
    localparam int TAG_LSB  = IDX_BITS + 1 + OFF_BIT;
    localparam int TAG_BITS = 32 - TAG_LSB;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [IDX_BITS-1:0] idx_t;

    // storage, way first
    tag_t                    tags  [2][SETS];
    dcache_types_pkg::word_t data  [2][SETS][dcache_types_pkg::WORDS_PER_BLOCK];
    logic [SETS-1:0]         valid [2];
    logic [SETS-1:0]         dirty [2];
    logic [SETS-1:0]         recent;  // way used last, per set

    idx_t       idx;
    tag_t       look_tag;
    logic [1:0] way_hit;

    assign idx      = arr.look_addr[TAG_LSB-1 -: IDX_BITS];
    assign look_tag = arr.look_addr[31 -: TAG_BITS];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][idx] && (tags[w][idx] == look_tag);
        end
    end

    assign arr.hit     = |way_hit;
    assign arr.hit_way = way_hit[1];

    // replace whichever way was not used last
    assign arr.victim_way   = ~recent[idx];
    assign arr.victim_valid = valid[arr.victim_way][idx];
    assign arr.victim_dirty = dirty[arr.victim_way][idx];
    assign arr.victim_tag   = tags[arr.victim_way][idx];

    assign arr.sel_word  = data[arr.sel_way][idx][arr.sel_off];
    assign arr.sel_dirty = dirty[arr.sel_way][idx];
    assign arr.sel_tag   = tags[arr.sel_way][idx];

    // payload
    always_ff @(posedge CLK) begin
        if (arr.wr_kind != dcache_fsm_pkg::WR_NONE) begin
            data[arr.sel_way][idx][arr.sel_off] <= arr.wr_data;
        end
        if (arr.wr_kind == dcache_fsm_pkg::WR_FILL_LAST) begin
            tags[arr.sel_way][idx] <= look_tag;
        end
    end

    // line state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int w = 0; w < 2; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            recent <= '0;
        end else begin
            case (arr.wr_kind)
                dcache_fsm_pkg::WR_STORE: begin
                    dirty[arr.sel_way][idx] <= 1'b1;
                end
                dcache_fsm_pkg::WR_FILL_LAST: begin
                    valid[arr.sel_way][idx] <= 1'b1;
                    dirty[arr.sel_way][idx] <= 1'b0;  // fresh from memory
                end
                default: begin
                end
            endcase
            if (arr.touch || arr.wr_kind == dcache_fsm_pkg::WR_FILL_LAST) begin
                recent[idx] <= arr.sel_way;
            end
        end
    end

    // fills only ever go to a way that misses, so a tag lives in one way at most
    a_one_way_hits: assert property (
        @(posedge CLK) disable iff (!nRST) !(way_hit[0] && way_hit[1])
    );

endmodule

//--- logic/array_if.sv
`timescale 1ns/1ps

interface array_if #(
    parameter int IDX_BITS = dcache_types_pkg::DEFAULT_IDX_BITS
);
    localparam int TAG_BITS = 32 - IDX_BITS - 1 - dcache_types_pkg::BYTE_OFF_BITS;

    // controller to array
    dcache_types_pkg::addr_t   look_addr;
    logic                      sel_way;
    logic                      sel_off;
    logic                      touch;     // access hit, mark sel_way as recent
    dcache_fsm_pkg::wr_kind_t  wr_kind;
    dcache_types_pkg::word_t   wr_data;

    // array to controller
    logic                      hit;
    logic                      hit_way;
    logic                      victim_way;
    logic                      victim_dirty;
    logic                      victim_valid;
    logic [TAG_BITS-1:0]       victim_tag;
    dcache_types_pkg::word_t   sel_word;
    logic                      sel_dirty;
    logic [TAG_BITS-1:0]       sel_tag;   // needed by the flush write-back

    modport ctrl (
        output look_addr, sel_way, sel_off, touch, wr_kind, wr_data,
        input  hit, hit_way, victim_way, victim_dirty, victim_valid, victim_tag,
        input  sel_word, sel_dirty, sel_tag
    );

    modport array (
        input  look_addr, sel_way, sel_off, touch, wr_kind, wr_data,
        output hit, hit_way, victim_way, victim_dirty, victim_valid, victim_tag,
        output sel_word, sel_dirty, sel_tag
    );

endinterface

//--- logic/dcache_fsm_pkg.sv
package dcache_fsm_pkg;

    // nine states, so one bit wider than three
    typedef enum logic [3:0] {
        ACCESS,
        WB0,
        WB1,
        FILL0,
        FILL1,
        FLUSH_SCAN,
        FLUSH0,
        FLUSH1,
        FLUSHED
    } ctrl_state_t;

    // what the array updates at the next edge
    typedef enum logic [1:0] {
        WR_NONE,
        WR_STORE,
        WR_FILL_WORD,
        WR_FILL_LAST
    } wr_kind_t;

endpackage

//--- logic/dcache_types_pkg.sv
package dcache_types_pkg;

    // one cpu data word
    typedef logic [31:0] word_t;

    // byte address as seen on both sides of the cache
    typedef logic [31:0] addr_t;

    // two words per block, so the block offset is a single bit
    localparam int WORDS_PER_BLOCK = 2;

    // word aligned accesses only, low bits are always zero
    localparam int BYTE_OFF_BITS = 2;

    // 8 sets unless the top level says otherwise
    localparam int DEFAULT_IDX_BITS = 3;

endpackage
